// ==== source/rom_bridge_pkg.sv ====
// shared widths and request types for the rom loader, the word store and the bus bridge
package rom_bridge_pkg;

    localparam int BYTE_ADDR_WIDTH = 23;   // rom byte address
    localparam int WORD_ADDR_WIDTH = 22;   // 16-bit word address

    typedef logic [BYTE_ADDR_WIDTH-1:0] byte_addr_t;
    typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;

    typedef logic [1:0] lane_sel_t;        // bit 0 selects the low byte
    typedef logic [3:0] bus_strb_t;        // all zero on a read

    // halves of a bus word, hi is the odd word of the pair
    typedef struct packed {
        logic [15:0] hi;
        logic [15:0] lo;
    } bus_half_t;

    typedef union packed {
        logic [31:0] word;
        bus_half_t   half;
    } bus_word_t;

    // one 16-bit store access, sent along with a toggle bit
    typedef struct packed {
        word_addr_t  addr;
        logic [15:0] wdata;
        lane_sel_t   ds;
        logic        we;
    } mem_req_t;

    // 32-bit access from the softcore side
    typedef struct packed {
        byte_addr_t  addr;
        bus_word_t   wdata;
        bus_strb_t   strb;
    } bus_req_t;

endpackage

// ==== source/rom_loader.sv ====
// packs the rom byte stream into 16-bit store writes, driving the loader channel of the top level
`timescale 1ns/100ps

module rom_loader (
    input  logic                     mclk,
    input  logic                     resetn,
    input  logic                     loading,
    input  logic [7:0]               rom_byte,
    input  logic                     rom_valid,
    output logic                     rom_ready,
    output logic                     loaded,
    output rom_bridge_pkg::mem_req_t mem_req,
    output logic                     req,
    input  logic                     ack
);

    logic                       loading_r;
    logic                       load_rise;
    logic                       load_fall;
    rom_bridge_pkg::byte_addr_t byte_addr;     // position of the next byte
    rom_bridge_pkg::byte_addr_t cur_addr;
    logic [7:0]                 even_byte;
    logic                       accept;
    logic                       issue;

    assign load_rise = loading & ~loading_r;
    assign load_fall = ~loading & loading_r;

    // a byte arriving together with the rise of loading is byte 0
    assign cur_addr  = load_rise ? '0 : byte_addr;
    assign rom_ready = (req == ack);           // back-pressure while a write is in flight
    assign accept    = rom_valid & rom_ready & loading;
    assign issue     = accept & cur_addr[0];   // one write per odd byte

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            loading_r <= 1'b0;
            loaded    <= 1'b0;
            byte_addr <= '0;
            req       <= 1'b0;
        end else begin
            loading_r <= loading;
            if (load_rise) begin
                loaded    <= 1'b0;
                byte_addr <= '0;
            end
            if (accept)
                byte_addr <= cur_addr + 1'b1;
            if (issue)
                req <= ~req;
            if (load_fall)
                loaded <= 1'b1;                // a trailing odd byte is simply dropped
        end
    end

    // even byte waits here for its odd partner
    always_ff @(posedge mclk) begin
        if (accept)
            even_byte <= rom_byte;
        if (issue) begin
            mem_req.addr  <= cur_addr[rom_bridge_pkg::BYTE_ADDR_WIDTH-1:1];
            mem_req.wdata <= {rom_byte, even_byte};   // even byte in the low lane
            mem_req.ds    <= 2'b11;
            mem_req.we    <= 1'b1;
        end
    end

    // the stream must stall in the cycle after a packed write goes out
    assert property (@(posedge mclk) disable iff (!resetn)
        issue |=> !accept);

endmodule

// ==== source/word_store.sv ====
// behavioural 16-bit word memory serving the loader and bridge channels with toggle handshakes
`timescale 1ns/100ps

module word_store #(
    parameter int STORE_ADDR_WIDTH = 10
) (
    input  logic                     mclk,
    input  logic                     resetn,
    input  rom_bridge_pkg::mem_req_t ld_req_s,
    input  logic                     ld_req,
    output logic                     ld_ack,
    input  rom_bridge_pkg::mem_req_t br_req_s,
    input  logic                     br_req,
    output logic                     br_ack,
    output logic [15:0]              rdata
);

    localparam int DEPTH = 1 << STORE_ADDR_WIDTH;

    logic [15:0]                   mem [DEPTH];
    logic                          ld_pend;
    logic                          br_pend;
    logic                          busy;
    logic                          grant;
    logic                          grant_br;
    rom_bridge_pkg::mem_req_t      gnt_req;
    logic                          s1_valid;   // access stage
    logic                          s1_br;
    rom_bridge_pkg::mem_req_t      s1_req;
    logic                          s2_valid;   // ack stage
    logic                          s2_br;
    logic [STORE_ADDR_WIDTH-1:0]   s1_idx;

    assign ld_pend  = (ld_req != ld_ack);
    assign br_pend  = (br_req != br_ack);
    assign busy     = s1_valid | s2_valid;     // one request at a time
    assign grant    = ~busy & (ld_pend | br_pend);
    assign grant_br = ~ld_pend;                // loader wins a tie
    assign gnt_req  = grant_br ? br_req_s : ld_req_s;

    // upper word address bits alias onto the same location
    assign s1_idx = s1_req.addr[STORE_ADDR_WIDTH-1:0];

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            s1_valid <= 1'b0;
            s1_br    <= 1'b0;
            s2_valid <= 1'b0;
            s2_br    <= 1'b0;
            ld_ack   <= 1'b0;
            br_ack   <= 1'b0;
        end else begin
            s1_valid <= grant;
            if (grant)
                s1_br <= grant_br;
            s2_valid <= s1_valid;
            s2_br    <= s1_br;
            if (s2_valid) begin
                if (s2_br)
                    br_ack <= ~br_ack;
                else
                    ld_ack <= ~ld_ack;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (grant)
            s1_req <= gnt_req;
    end

    // per-lane writes, reads hold rdata until the next read
    always_ff @(posedge mclk) begin
        if (s1_valid) begin
            if (s1_req.we) begin
                if (s1_req.ds[0])
                    mem[s1_idx][7:0] <= s1_req.wdata[7:0];
                if (s1_req.ds[1])
                    mem[s1_idx][15:8] <= s1_req.wdata[15:8];
            end else begin
                rdata <= mem[s1_idx];
            end
        end
    end

    // requesters never send a write that touches no lane
    assert property (@(posedge mclk) disable iff (!resetn)
        (grant && gnt_req.we) |-> (gnt_req.ds != 2'b00));

endmodule

// ==== source/bus_bridge.sv ====
// splits 32-bit strobed softcore accesses into one or two 16-bit word store requests
`timescale 1ns/100ps

module bus_bridge (
    input  logic                      mclk,
    input  logic                      resetn,
    input  logic                      bus_valid,
    input  rom_bridge_pkg::bus_req_t  bus_req,
    output logic                      bus_ready,
    output rom_bridge_pkg::bus_word_t bus_rdata,
    output rom_bridge_pkg::mem_req_t  mem_req,
    output logic                      req,
    input  logic                      ack,
    input  logic [15:0]               rdata
);

    typedef enum logic [2:0] {
        st_idle_req0,
        st_wait0_req1,
        st_data0,
        st_wait1,
        st_data1
    } state_t;

    state_t                    state;
    logic                      valid_r;
    logic                      ready_d;
    logic                      new_req_t;
    logic                      write;
    logic                      word_sel;   // which half of the bus word
    rom_bridge_pkg::lane_sel_t ds;
    rom_bridge_pkg::bus_word_t rd_word;

    assign write = (bus_req.strb != 4'b0000);

    // rising valid, or valid held over the cycle after ready
    assign new_req_t = bus_valid & (~valid_r | ready_d);

    always_comb begin
        mem_req.addr  = {bus_req.addr[rom_bridge_pkg::BYTE_ADDR_WIDTH-1:2], word_sel};
        mem_req.wdata = word_sel ? bus_req.wdata.half.hi : bus_req.wdata.half.lo;
        mem_req.ds    = ds;
        mem_req.we    = write;
    end

    assign bus_rdata = rd_word;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            state     <= st_idle_req0;
            valid_r   <= 1'b0;
            ready_d   <= 1'b0;
            req       <= 1'b0;
            bus_ready <= 1'b0;
        end else begin
            valid_r   <= bus_valid;
            ready_d   <= bus_ready;
            bus_ready <= 1'b0;                 // single-cycle pulse

            case (state)
                st_idle_req0: begin
                    if (new_req_t) begin
                        req <= ~req;
                        if (write && bus_req.strb[1:0] == 2'b00) begin
                            word_sel <= 1'b1;  // upper word only
                            ds       <= bus_req.strb[3:2];
                            state    <= st_wait1;
                        end else begin
                            word_sel <= 1'b0;
                            ds       <= write ? bus_req.strb[1:0] : 2'b11;
                            state    <= st_wait0_req1;
                        end
                    end
                end
                st_wait0_req1: begin
                    if (req == ack) begin
                        if (write && bus_req.strb[3:2] == 2'b00) begin
                            bus_ready <= 1'b1; // lower word only and no second access
                            state     <= st_idle_req0;
                        end else begin
                            req      <= ~req;
                            word_sel <= 1'b1;
                            ds       <= write ? bus_req.strb[3:2] : 2'b11;
                            state    <= write ? st_wait1 : st_data0;
                        end
                    end
                end
                st_data0: begin
                    rd_word.half.lo <= rdata;
                    state           <= st_wait1;
                end
                st_wait1: begin
                    if (req == ack) begin
                        if (write) begin
                            bus_ready <= 1'b1;
                            state     <= st_idle_req0;
                        end else begin
                            state <= st_data1;
                        end
                    end
                end
                st_data1: begin
                    rd_word.half.hi <= rdata;
                    bus_ready       <= 1'b1;
                    state           <= st_idle_req0;
                end
                default: state <= st_idle_req0;
            endcase
        end
    end

    // word requests read the bus fields live, so they must hold until ready
    assert property (@(posedge mclk) disable iff (!resetn)
        (bus_valid && !bus_ready) |=> ($stable(bus_req.addr) && $stable(bus_req.strb)));

endmodule

// ==== source/rom_bridge_top.sv ====
// top level joining the rom loader and the bus bridge to the shared word store
`timescale 1ns/100ps

module rom_bridge_top #(
    parameter int STORE_ADDR_WIDTH = 10
) (
    input  logic                      mclk,
    input  logic                      resetn,
    input  logic                      loading,
    input  logic [7:0]                rom_byte,
    input  logic                      rom_valid,
    output logic                      rom_ready,
    output logic                      loaded,
    input  logic                      bus_valid,
    input  rom_bridge_pkg::bus_req_t  bus_req,
    output logic                      bus_ready,
    output rom_bridge_pkg::bus_word_t bus_rdata
);

    rom_bridge_pkg::mem_req_t ld_mem_req;
    logic                     ld_req;
    logic                     ld_ack;
    rom_bridge_pkg::mem_req_t br_mem_req;
    logic                     br_req;
    logic                     br_ack;
    logic [15:0]              store_rdata;   // shared by both channels

    rom_loader loader_i (
        .mclk      (mclk),
        .resetn    (resetn),
        .loading   (loading),
        .rom_byte  (rom_byte),
        .rom_valid (rom_valid),
        .rom_ready (rom_ready),
        .loaded    (loaded),
        .mem_req   (ld_mem_req),
        .req       (ld_req),
        .ack       (ld_ack)
    );

    word_store #(
        .STORE_ADDR_WIDTH (STORE_ADDR_WIDTH)
    ) store_i (
        .mclk     (mclk),
        .resetn   (resetn),
        .ld_req_s (ld_mem_req),
        .ld_req   (ld_req),
        .ld_ack   (ld_ack),
        .br_req_s (br_mem_req),
        .br_req   (br_req),
        .br_ack   (br_ack),
        .rdata    (store_rdata)
    );

    bus_bridge bridge_i (
        .mclk      (mclk),
        .resetn    (resetn),
        .bus_valid (bus_valid),
        .bus_req   (bus_req),
        .bus_ready (bus_ready),
        .bus_rdata (bus_rdata),
        .mem_req   (br_mem_req),
        .req       (br_req),
        .ack       (br_ack),
        .rdata     (store_rdata)
    );

endmodule

// ==== verification/tb_checks.svh ====
// error counters and typed compare tasks, included inside the rom bridge testbench module
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int word_errors  = 0;
int flag_errors  = 0;
int other_errors = 0;
int words_seen   = 0;    // bus reads compared so far

task automatic check_word(input string test, input rom_bridge_pkg::bus_word_t exp,
                          input rom_bridge_pkg::bus_word_t act);
    words_seen++;
    if (act !== exp) begin
        word_errors++;
        $display("** Error [%s] expected %08h actual %08h at %0t", test, exp.word, act.word,
                 $time);
    end
endtask

task automatic check_flag(input string test, input logic exp, input logic act);
    if (act !== exp) begin
        flag_errors++;
        $display("** Error [%s] expected %b actual %b at %0t", test, exp, act, $time);
    end
endtask

// every issued read should have passed through the compare process
task automatic check_read_count(input int issued);
    if (words_seen != issued) begin
        other_errors++;
        $display("%0d bus reads were compared but %0d were issued", words_seen, issued);
    end
endtask

function automatic int error_count();
    return word_errors + flag_errors + other_errors;
endfunction

task automatic report_summary();
    $display("summary: %0d reads compared, errors %0d word, %0d flag, %0d other",
             words_seen, word_errors, flag_errors, other_errors);
endtask

`endif

// ==== verification/tb_top.sv ====
// testbench for rom_bridge_top, loads rom bytes and checks bus reads against a byte model
`timescale 1ns/100ps

module tb_top;

    localparam int store_aw        = 10;
    localparam int store_bytes     = 2 << store_aw;            // two bytes per word
    localparam int n_bytes         = 64 + 32 + 9 + 48;
    localparam int n_access        = 16 + 16 + 4 + 64 + 48 + 32;
    localparam int watchdog_cycles = (n_bytes + n_access) * 20 + 200;

    typedef logic [store_aw:0] maddr_t;                        // byte index into the store

    logic                      mclk;
    logic                      resetn;
    logic                      loading;
    logic [7:0]                rom_byte;
    logic                      rom_valid;
    logic                      rom_ready;
    logic                      loaded;
    logic                      bus_valid;
    rom_bridge_pkg::bus_req_t  bus_req;
    logic                      bus_ready;
    rom_bridge_pkg::bus_word_t bus_rdata;

    logic [7:0]  model [store_bytes];
    logic [31:0] rand_state   = 32'd1699;
    string       test_name    = "reset";
    int          reads_issued = 0;

    `include "tb_checks.svh"

    rom_bridge_top #(
        .STORE_ADDR_WIDTH (store_aw)
    ) dut_i (
        .mclk      (mclk),
        .resetn    (resetn),
        .loading   (loading),
        .rom_byte  (rom_byte),
        .rom_valid (rom_valid),
        .rom_ready (rom_ready),
        .loaded    (loaded),
        .bus_valid (bus_valid),
        .bus_req   (bus_req),
        .bus_ready (bus_ready),
        .bus_rdata (bus_rdata)
    );

    initial begin
        mclk = 1'b0;
        forever #10 mclk = ~mclk;
    end

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic rom_bridge_pkg::bus_strb_t pick_strobe();
        rom_bridge_pkg::bus_strb_t choices [8];
        choices = '{4'hc, 4'h3, 4'h1, 4'h2, 4'h4, 4'h8, 4'h6, 4'hb};
        return choices[3'(next_random() >> 29)];
    endfunction

    // least significant byte first, bits 1:0 of the address are ignored
    function automatic rom_bridge_pkg::bus_word_t expected_word(
            input rom_bridge_pkg::byte_addr_t addr);
        maddr_t                    base;
        rom_bridge_pkg::bus_word_t w;
        base   = maddr_t'(addr) & ~maddr_t'(3);               // upper bits alias
        w.word = {model[base + maddr_t'(3)], model[base + maddr_t'(2)],
                  model[base + maddr_t'(1)], model[base]};
        return w;
    endfunction

    task automatic load_bytes(input int count);
        logic [7:0] even_b;
        logic [7:0] b;
        int         i;
        loading = 1'b1;
        @(posedge mclk);
        #2;
        check_flag({test_name, " loaded at start"}, 1'b0, loaded);
        for (i = 0; i < count; i++) begin
            b = 8'(next_random() >> 24);
            repeat (int'(next_random() >> 30)) begin       // gap in rom_valid
                @(posedge mclk);
                #2;
            end
            rom_byte  = b;
            rom_valid = 1'b1;
            while (!rom_ready) begin
                @(posedge mclk);
                #2;
            end
            @(posedge mclk);                                  // byte taken here
            #2;
            rom_valid = 1'b0;
            if (i % 2 == 0) begin
                even_b = b;
            end else begin
                model[maddr_t'(i - 1)] = even_b;
                model[maddr_t'(i)]     = b;
            end
        end
        check_flag({test_name, " loaded at end"}, 1'b0, loaded);
        loading = 1'b0;
        @(posedge mclk);
        #2;
        check_flag({test_name, " loaded after load"}, 1'b1, loaded);
        while (!rom_ready) begin                              // last write still in flight
            @(posedge mclk);
            #2;
        end
    endtask

    task automatic bus_access(input int addr, input logic [31:0] data,
                              input rom_bridge_pkg::bus_strb_t strb);
        maddr_t base;
        int     k;
        bus_req.addr       = rom_bridge_pkg::byte_addr_t'(addr);
        bus_req.wdata.word = data;
        bus_req.strb       = strb;
        bus_valid          = 1'b1;
        do begin
            @(posedge mclk);
            #2;
        end while (!bus_ready);
        bus_valid = 1'b0;
        base = maddr_t'(addr) & ~maddr_t'(3);
        for (k = 0; k < 4; k++) begin
            if (strb[k])
                model[base + maddr_t'(k)] = data[8*k +: 8];
        end
        if (strb == 4'h0)
            reads_issued++;
        @(posedge mclk);                                      // idle so valid rises again
        #2;
    endtask

    task automatic read_words(input int start, input int count);
        int i;
        for (i = 0; i < count; i++)
            bus_access(start + 4 * i, 32'h0, 4'h0);
    endtask

    // read data is stable at the falling edge of the ready cycle
    always @(negedge mclk) begin
        if (resetn && bus_ready && bus_req.strb == 4'h0)
            check_word(test_name, expected_word(bus_req.addr), bus_rdata);
    end

    initial begin
        repeat (watchdog_cycles) @(posedge mclk);
        $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int a;
        int i;
        resetn    = 1'b0;
        loading   = 1'b0;
        rom_byte  = 8'h00;
        rom_valid = 1'b0;
        bus_valid = 1'b0;
        bus_req   = '0;
        repeat (2) @(posedge mclk);
        #2;
        resetn = 1'b1;
        check_flag("reset rom_ready", 1'b1, rom_ready);
        check_flag("reset loaded", 1'b0, loaded);
        check_flag("reset bus_ready", 1'b0, bus_ready);

        test_name = "load then read";
        load_bytes(64);
        read_words(0, 16);
        test_name = "second load";                            // restarts at byte 0
        load_bytes(32);
        read_words(0, 16);
        test_name = "trailing odd byte";
        load_bytes(9);
        read_words(0, 4);

        test_name = "partial writes";
        for (i = 0; i < 16; i++)
            bus_access(512 + 4 * i, next_random(), 4'hf);
        for (i = 0; i < 32; i++)
            bus_access(512 + 4 * int'(next_random() >> 28), next_random(), pick_strobe());
        read_words(512, 16);

        test_name = "concurrent channels";
        fork
            load_bytes(48);
            for (a = 1024; a < 1088; a += 4) begin
                bus_access(a, next_random(), 4'hf);
                bus_access(a, next_random(), pick_strobe());
                bus_access(a, 32'h0, 4'h0);
            end
        join
        read_words(0, 16);
        read_words(1024, 16);

        check_read_count(reads_issued);
        report_summary();
        if (error_count() == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+verification
source/rom_bridge_pkg.sv
source/rom_loader.sv
source/word_store.sv
source/bus_bridge.sv
source/rom_bridge_top.sv
verification/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_TEXT ?= All tests passed!

SOURCES := $(wildcard source/*.sv verification/*.sv verification/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
